/* rtl/cam_cfg_pkg.sv */
`default_nettype none

package cam_cfg_pkg;

	typedef logic [31:0] cfg_word_t;   // Device, register address, data
	typedef logic [7:0]  byte_t;
	typedef logic [4:0]  cfg_index_t;  // Holds 0 to CFG_ENTRIES

	localparam int    CFG_ENTRIES     = 16;
	localparam byte_t CAM_DEV_ADDR    = 8'h78;  // Sensor write address

	// Scaled down for simulation
	localparam int    SETTLE_CYCLES   = 64;
	localparam int    SETTLE_W        = $clog2(SETTLE_CYCLES);
	localparam int    SCL_QUARTER     = 4;
	localparam int    QTR_W           = $clog2(SCL_QUARTER);

	localparam int    BYTES_PER_WRITE = 4;

	typedef enum logic [2:0] {
		SEQ_BOOT,    // Issue next table entry
		SEQ_WAIT,
		SEQ_SETTLE,
		SEQ_READY,
		SEQ_EXT      // External write in flight
	} seq_state_t;

	typedef enum logic [2:0] {
		I2C_IDLE,
		I2C_START,
		I2C_BIT,
		I2C_ACK,
		I2C_STOP
	} i2c_state_t;

endpackage

`default_nettype wire

/* rtl/cfg_rom.sv */
`default_nettype none
`timescale 1ns/1ps

module cfg_rom (
	input  cam_cfg_pkg::cfg_index_t rom_index,
	output cam_cfg_pkg::cfg_word_t  rom_word
);

	import cam_cfg_pkg::*;

	always_comb begin
		case (rom_index)
			5'd0: begin
				rom_word = {CAM_DEV_ADDR, 16'h3103, 8'h11};  // Clock from pad
			end
			5'd1: begin
				rom_word = {CAM_DEV_ADDR, 16'h3008, 8'h82};  // Soft reset
			end
			5'd2: begin
				rom_word = {CAM_DEV_ADDR, 16'h3008, 8'h42};  // Power down
			end
			5'd3: begin
				rom_word = {CAM_DEV_ADDR, 16'h3103, 8'h03};  // Clock from PLL
			end
			5'd4: begin
				rom_word = {CAM_DEV_ADDR, 16'h3017, 8'hff};  // Pad output enables
			end
			5'd5: begin
				rom_word = {CAM_DEV_ADDR, 16'h3018, 8'hff};
			end
			5'd6: begin
				rom_word = {CAM_DEV_ADDR, 16'h3034, 8'h1a};
			end
			5'd7: begin
				rom_word = {CAM_DEV_ADDR, 16'h3037, 8'h13};  // PLL root and pre divider
			end
			5'd8: begin
				rom_word = {CAM_DEV_ADDR, 16'h3108, 8'h01};  // PCLK and SCLK dividers
			end
			5'd9:    rom_word = {CAM_DEV_ADDR, 16'h3630, 8'h36};
			5'd10:   rom_word = {CAM_DEV_ADDR, 16'h3631, 8'h0e};
			5'd11:   rom_word = {CAM_DEV_ADDR, 16'h3632, 8'he2};
			5'd12:   rom_word = {CAM_DEV_ADDR, 16'h3633, 8'h12};
			5'd13:   rom_word = {CAM_DEV_ADDR, 16'h3621, 8'he0};
			5'd14:   rom_word = {CAM_DEV_ADDR, 16'h3704, 8'ha0};
			5'd15:   rom_word = {CAM_DEV_ADDR, 16'h3703, 8'h5a};
			default: rom_word = '0;  // Past the end of the table
		endcase
	end

endmodule

`default_nettype wire

/* rtl/i2c_write_master.sv */
`default_nettype none
`timescale 1ns/1ps

module i2c_write_master (
	input  logic                   sclk,
	input  logic                   s_rst_n,
	input  logic                   xfer_start,
	input  cam_cfg_pkg::cfg_word_t xfer_word,
	output logic                   xfer_done,
	output logic                   xfer_nack,
	output logic                   iic_scl,
	inout  wire                    iic_sda
);

	import cam_cfg_pkg::*;

	i2c_state_t       state;
	logic [QTR_W-1:0] qcnt;
	logic [1:0]       phase;      // Quarter within one SCL period
	logic [1:0]       byte_cnt;
	logic [2:0]       bit_cnt;
	logic             ack_high;
	logic             aborted;
	logic             tick;
	logic             last_phase;
	logic             sda_low;
	cfg_word_t        word_r;
	byte_t            cur_byte;

	assign tick       = (qcnt == QTR_W'(SCL_QUARTER - 1));
	assign last_phase = tick && (phase == 2'd3);
	assign cur_byte   = word_r[8 * (BYTES_PER_WRITE - 1 - byte_cnt) +: 8];  // MSB first

	// Idle holds the quarter timer at the start of a period
	always_ff @(posedge sclk or negedge s_rst_n) begin
		if (!s_rst_n) begin
			qcnt  <= '0;
			phase <= '0;
		end else if (state == I2C_IDLE) begin
			qcnt  <= '0;
			phase <= '0;
		end else if (tick) begin
			qcnt  <= '0;
			phase <= phase + 2'd1;
		end else begin
			qcnt <= qcnt + 1'b1;
		end
	end

	always_ff @(posedge sclk or negedge s_rst_n) begin
		if (!s_rst_n) begin
			state     <= I2C_IDLE;
			byte_cnt  <= '0;
			bit_cnt   <= '0;
			ack_high  <= 1'b0;
			aborted   <= 1'b0;
			xfer_done <= 1'b0;
			xfer_nack <= 1'b0;
		end else begin
			xfer_done <= 1'b0;
			xfer_nack <= 1'b0;

			case (state)
				I2C_IDLE: begin
					if (xfer_start) begin
						state    <= I2C_START;
						byte_cnt <= '0;
						bit_cnt  <= '0;
						aborted  <= 1'b0;
					end
				end
				I2C_START: begin
					if (last_phase)
						state <= I2C_BIT;
				end
				I2C_BIT: begin
					if (last_phase) begin
						bit_cnt <= bit_cnt + 3'd1;  // Wraps to 0 for next byte
						if (bit_cnt == 3'd7)
							state <= I2C_ACK;
					end
				end
				I2C_ACK: begin
					// Sample in the middle of SCL high
					if (tick && phase == 2'd1)
						ack_high <= iic_sda;
					if (last_phase) begin
						if (ack_high) begin
							aborted <= 1'b1;
							state   <= I2C_STOP;  // Skip remaining bytes
						end else if (byte_cnt == 2'(BYTES_PER_WRITE - 1)) begin
							state <= I2C_STOP;
						end else begin
							byte_cnt <= byte_cnt + 2'd1;
							state    <= I2C_BIT;
						end
					end
				end
				I2C_STOP: begin
					if (last_phase) begin
						state     <= I2C_IDLE;
						xfer_done <= 1'b1;
						xfer_nack <= aborted;
					end
				end
				default: begin
					state <= I2C_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge sclk) begin
		if (state == I2C_IDLE && xfer_start)
			word_r <= xfer_word;
	end

	// Bus levels decoded from state and quarter
	always_comb begin
		iic_scl = 1'b1;
		sda_low = 1'b0;
		case (state)
			I2C_START: begin
				iic_scl = (phase != 2'd3);
				sda_low = (phase != 2'd0);  // SDA falls with SCL high
			end
			I2C_BIT: begin
				iic_scl = (phase == 2'd1) || (phase == 2'd2);
				sda_low = ~cur_byte[~bit_cnt];
			end
			I2C_ACK: begin
				iic_scl = (phase == 2'd1) || (phase == 2'd2);
				sda_low = 1'b0;  // Slave drives
			end
			I2C_STOP: begin
				iic_scl = (phase != 2'd0);
				sda_low = (phase < 2'd2);   // SDA rises with SCL high
			end
			default: begin
				iic_scl = 1'b1;
				sda_low = 1'b0;
			end
		endcase
	end

	assign iic_sda = sda_low ? 1'b0 : 1'bz;  // Open drain

endmodule

`default_nettype wire

/* rtl/cfg_sequencer.sv */
`default_nettype none
`timescale 1ns/1ps

module cfg_sequencer (
	input  logic                    sclk,
	input  logic                    s_rst_n,
	input  logic                    ext_start,
	input  cam_cfg_pkg::cfg_word_t  ext_wdata,
	input  cam_cfg_pkg::cfg_word_t  rom_word,
	input  logic                    xfer_done,
	input  logic                    xfer_nack,
	output cam_cfg_pkg::cfg_index_t rom_index,
	output logic                    xfer_start,
	output cam_cfg_pkg::cfg_word_t  xfer_word,
	output logic                    busy,
	output logic                    cfg_done,
	output logic                    nack_seen
);

	import cam_cfg_pkg::*;

	seq_state_t          state;
	logic [SETTLE_W-1:0] settle_cnt;
	logic                table_end;
	logic                issue_rom;
	logic                accept_ext;

	// rom_index runs one ahead of the entry in flight
	assign table_end  = (rom_index == cfg_index_t'(CFG_ENTRIES));
	assign issue_rom  = (state == SEQ_BOOT) ||
	                    (state == SEQ_WAIT && xfer_done && !table_end);
	assign accept_ext = (state == SEQ_READY) && ext_start;  // Dropped otherwise

	always_ff @(posedge sclk or negedge s_rst_n) begin
		if (!s_rst_n) begin
			state      <= SEQ_BOOT;
			rom_index  <= '0;
			settle_cnt <= '0;
			xfer_start <= 1'b0;
			busy       <= 1'b0;
			cfg_done   <= 1'b0;
			nack_seen  <= 1'b0;
		end else begin
			xfer_start <= issue_rom || accept_ext;
			if (issue_rom)
				rom_index <= rom_index + 1'b1;

			case (state)
				SEQ_BOOT: begin
					state <= SEQ_WAIT;
				end
				SEQ_WAIT: begin
					// Table writes ignore NACK
					if (xfer_done && table_end) begin
						state      <= SEQ_SETTLE;
						settle_cnt <= SETTLE_W'(1);
					end
				end
				SEQ_SETTLE: begin
					if (settle_cnt == SETTLE_W'(SETTLE_CYCLES - 1)) begin
						cfg_done <= 1'b1;  // Sticky from here on
						state    <= SEQ_READY;
					end else begin
						settle_cnt <= settle_cnt + 1'b1;
					end
				end
				SEQ_READY: begin
					if (accept_ext) begin
						busy      <= 1'b1;
						nack_seen <= 1'b0;
						state     <= SEQ_EXT;
					end
				end
				SEQ_EXT: begin
					if (xfer_done) begin
						busy  <= 1'b0;
						state <= SEQ_READY;
						if (xfer_nack)
							nack_seen <= 1'b1;
					end
				end
				default: begin
					state <= SEQ_BOOT;
				end
			endcase
		end
	end

	always_ff @(posedge sclk) begin
		if (issue_rom)
			xfer_word <= rom_word;
		else if (accept_ext)
			xfer_word <= ext_wdata;
	end

endmodule

`default_nettype wire

/* rtl/cam_cfg_top.sv */
`default_nettype none
`timescale 1ns/1ps

module cam_cfg_top (
	input  logic                   sclk,
	input  logic                   s_rst_n,
	input  logic                   ext_start,
	input  cam_cfg_pkg::cfg_word_t ext_wdata,
	output logic                   iic_scl,
	inout  wire                    iic_sda,
	output logic                   busy,
	output logic                   cfg_done,
	output logic                   nack_seen
);

	import cam_cfg_pkg::*;

	cfg_index_t rom_index;
	cfg_word_t  rom_word;
	cfg_word_t  xfer_word;
	logic       xfer_start;
	logic       xfer_done;
	logic       xfer_nack;

	cfg_sequencer u_cfg_sequencer (
		.sclk       (sclk),
		.s_rst_n    (s_rst_n),
		.ext_start  (ext_start),
		.ext_wdata  (ext_wdata),
		.rom_word   (rom_word),
		.xfer_done  (xfer_done),
		.xfer_nack  (xfer_nack),
		.rom_index  (rom_index),
		.xfer_start (xfer_start),
		.xfer_word  (xfer_word),
		.busy       (busy),
		.cfg_done   (cfg_done),
		.nack_seen  (nack_seen)
	);

	cfg_rom u_cfg_rom (
		.rom_index (rom_index),
		.rom_word  (rom_word)
	);

	i2c_write_master u_i2c_write_master (
		.sclk       (sclk),
		.s_rst_n    (s_rst_n),
		.xfer_start (xfer_start),
		.xfer_word  (xfer_word),
		.xfer_done  (xfer_done),
		.xfer_nack  (xfer_nack),
		.iic_scl    (iic_scl),
		.iic_sda    (iic_sda)
	);

endmodule

`default_nettype wire

/* tests/i2c_props.sv */
`default_nettype none
`timescale 1ns/1ps

module i2c_props (
	input logic                    sclk,
	input logic                    s_rst_n,
	input cam_cfg_pkg::i2c_state_t state,
	input logic                    iic_scl,
	input wire                     iic_sda,
	input logic                    xfer_start,
	input logic                    xfer_done
);

	import cam_cfg_pkg::*;

	int fail_cnt = 0;

	// Data and ACK bits move only while SCL is low
	sda_stable: assert property (@(posedge sclk) disable iff (!s_rst_n)
		(iic_scl && $past(iic_scl) && (state == I2C_BIT || state == I2C_ACK))
		|-> $stable(iic_sda))
	else begin
		fail_cnt++;
		$error("SDA changed while SCL was high inside a byte");
	end

	// Done comes once the stop has left the bus released
	done_pulse: assert property (@(posedge sclk) disable iff (!s_rst_n)
		xfer_done |-> (iic_scl && iic_sda) ##1 !xfer_done)
	else begin
		fail_cnt++;
		$error("xfer_done was not a single pulse on a released bus");
	end

	start_idle: assert property (@(posedge sclk) disable iff (!s_rst_n)
		xfer_start |-> state == I2C_IDLE)
	else begin
		fail_cnt++;
		$error("xfer_start while the I2C engine was not idle");
	end

endmodule

bind i2c_write_master i2c_props u_props (
	.sclk       (sclk),
	.s_rst_n    (s_rst_n),
	.state      (state),
	.iic_scl    (iic_scl),
	.iic_sda    (iic_sda),
	.xfer_start (xfer_start),
	.xfer_done  (xfer_done)
);

`default_nettype wire

/* tests/i2c_slave_model.sv */
`default_nettype none
`timescale 1ns/1ps

module i2c_slave_model (
	input  wire sclk,
	input  wire iic_scl,
	inout  wire iic_sda,
	input  int  nack_at  // Byte index to NACK or -1 for none
);

	import cam_cfg_pkg::*;

	logic      scl_q;
	logic      sda_q;
	logic      sda_drv;
	logic      active;
	logic      ack_clk;
	int        bit_cnt;
	int        byte_cnt;
	byte_t     shreg;
	cfg_word_t rx_word;
	int        n_rec;
	cfg_word_t rec_word_q[$];  // Bytes left aligned with missing ones zero
	int        rec_len_q[$];

	assign iic_sda = sda_drv ? 1'b0 : 1'bz;

	initial begin
		scl_q   = 1'b1;
		sda_q   = 1'b1;
		sda_drv = 1'b0;
		active  = 1'b0;
		ack_clk = 1'b0;
		n_rec   = 0;
	end

	// Bus edges seen one system clock late
	always @(posedge sclk) begin
		scl_q <= iic_scl;
		sda_q <= iic_sda;
		if (scl_q && iic_scl && sda_q && !iic_sda) begin
			active   <= 1'b1;  // Start
			ack_clk  <= 1'b0;
			bit_cnt  <= 0;
			byte_cnt <= 0;
			rx_word  <= '0;
		end else if (scl_q && iic_scl && !sda_q && iic_sda) begin
			if (active) begin  // Stop closes the record
				rec_word_q.push_back(rx_word);
				rec_len_q.push_back(byte_cnt);
				n_rec <= n_rec + 1;
			end
			active  <= 1'b0;
			sda_drv <= 1'b0;
		end else if (active && !scl_q && iic_scl) begin
			if (!ack_clk) begin
				shreg   <= {shreg[6:0], iic_sda};
				bit_cnt <= bit_cnt + 1;
			end
		end else if (active && scl_q && !iic_scl) begin
			if (ack_clk) begin
				ack_clk <= 1'b0;  // Release after the ninth clock
				sda_drv <= 1'b0;
			end else if (bit_cnt == 8) begin
				if (byte_cnt < BYTES_PER_WRITE)
					rx_word[8 * (BYTES_PER_WRITE - 1 - byte_cnt) +: 8] <= shreg;
				byte_cnt <= byte_cnt + 1;
				bit_cnt  <= 0;
				ack_clk  <= 1'b1;
				sda_drv  <= (byte_cnt != nack_at);  // Low is ACK
			end
		end
	end

endmodule

`default_nettype wire

/* tests/tb_cam_cfg.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_cam_cfg;

	import cam_cfg_pkg::*;

	localparam int N_RANDOM   = 40;
	localparam int N_EXT      = N_RANDOM + 2;          // Plus NACK write and the one after
	localparam int WRITE_CYC  = 38 * 4 * SCL_QUARTER;  // Start, 36 bit clocks, stop
	localparam int MAX_CYCLES = (CFG_ENTRIES + N_EXT) * (WRITE_CYC + 100) + SETTLE_CYCLES + 2000;

	logic      sclk;
	logic      s_rst_n;
	logic      ext_start;
	cfg_word_t ext_wdata;
	logic      iic_scl;
	wire       iic_sda;
	logic      busy;
	logic      cfg_done;
	logic      nack_seen;
	int        seed;
	int        errors;
	int        checks;
	int        accepted;
	int        nack_at;
	int        cycles;
	logic      done_seen;
	cfg_word_t exp_word_q[$];
	int        exp_len_q[$];

	// Sensor table for device 8'h78
	cfg_word_t ref_table [CFG_ENTRIES] = '{
		32'h7831_0311, 32'h7830_0882, 32'h7830_0842, 32'h7831_0303,
		32'h7830_17ff, 32'h7830_18ff, 32'h7830_341a, 32'h7830_3713,
		32'h7831_0801, 32'h7836_3036, 32'h7836_310e, 32'h7836_32e2,
		32'h7836_3312, 32'h7836_21e0, 32'h7837_04a0, 32'h7837_035a
	};

	pullup (iic_sda);

	cam_cfg_top uut (
		.sclk      (sclk),
		.s_rst_n   (s_rst_n),
		.ext_start (ext_start),
		.ext_wdata (ext_wdata),
		.iic_scl   (iic_scl),
		.iic_sda   (iic_sda),
		.busy      (busy),
		.cfg_done  (cfg_done),
		.nack_seen (nack_seen)
	);

	i2c_slave_model u_slave (
		.sclk    (sclk),
		.iic_scl (iic_scl),
		.iic_sda (iic_sda),
		.nack_at (nack_at)
	);

	initial begin
		sclk = 1'b0;
		forever #50 sclk = ~sclk;
	end

	task automatic compare_value(input string name, input logic [31:0] got,
	                             input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_records();
		cfg_word_t got;
		int        len;
		while (u_slave.rec_word_q.size() > 0) begin
			got = u_slave.rec_word_q.pop_front();
			len = u_slave.rec_len_q.pop_front();
			if (exp_word_q.size() == 0) begin
				errors++;
				$display("Unexpected write %h of %0d bytes on the bus at %0t", got, len, $time);
			end else begin
				compare_value("write data", got, exp_word_q.pop_front());
				compare_value("write length", len, exp_len_q.pop_front());
			end
		end
	endtask

	// Called on a falling edge with busy low
	task automatic ext_write(input cfg_word_t w, input int nack_byte);
		nack_at   = nack_byte;
		ext_start = 1'b1;
		ext_wdata = w;
		if (nack_byte < 0) begin
			exp_word_q.push_back(w);
			exp_len_q.push_back(BYTES_PER_WRITE);
		end else begin
			exp_word_q.push_back(w & (32'hffff_ffff << (8 * (3 - nack_byte))));
			exp_len_q.push_back(nack_byte + 1);
		end
		accepted++;
		@(negedge sclk);
		ext_start = 1'b0;
		compare_value("busy", 32'(busy), 32'd1);
		compare_value("nack_seen", 32'(nack_seen), 32'd0);
		while (busy) begin
			@(negedge sclk);
			ext_start = busy && (($random(seed) & 63) == 0);  // Must be dropped
			ext_wdata = $random(seed);
		end
		compare_value("nack_seen", 32'(nack_seen), (nack_byte < 0) ? 32'd0 : 32'd1);
		nack_at = -1;
	endtask

	initial begin
		seed      = 32'h0479_33c0;
		errors    = 0;
		checks    = 0;
		accepted  = 0;
		nack_at   = -1;
		s_rst_n   = 1'b0;
		ext_start = 1'b0;
		ext_wdata = '0;
		repeat (5) @(posedge sclk);
		@(negedge sclk);
		s_rst_n = 1'b1;
		foreach (ref_table[i]) begin
			exp_word_q.push_back(ref_table[i]);
			exp_len_q.push_back(BYTES_PER_WRITE);
		end
		while (!cfg_done) begin
			@(negedge sclk);
			compare_value("busy", 32'(busy), 32'd0);
			ext_start = !cfg_done && (($random(seed) & 127) == 0);  // Early, ignored
			ext_wdata = $random(seed);
		end
		compare_value("table writes", u_slave.n_rec, CFG_ENTRIES);
		check_records();
		for (int i = 0; i < N_RANDOM; i++) begin
			repeat ($random(seed) & 7) @(negedge sclk);
			ext_write($random(seed), -1);
		end
		check_records();
		ext_write($random(seed), $random(seed) & 3);
		ext_write($random(seed), -1);  // Clears nack_seen
		check_records();
		compare_value("write count", u_slave.n_rec, CFG_ENTRIES + accepted);
		compare_value("missing writes", exp_word_q.size(), 0);
		$display("Checks: %0d, errors: %0d, assertion failures: %0d",
		         checks, errors, uut.u_i2c_write_master.u_props.fail_cnt);
		if (errors == 0 && uut.u_i2c_write_master.u_props.fail_cnt == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	// cfg_done waits for every table write, then holds
	initial done_seen = 1'b0;
	always @(negedge sclk) begin
		if (cfg_done && u_slave.n_rec < CFG_ENTRIES) begin
			errors++;
			$display("cfg_done high at %0t before all table writes were seen", $time);
		end
		if (done_seen && !cfg_done) begin
			errors++;
			$display("cfg_done dropped at %0t", $time);
		end
		done_seen = done_seen || (cfg_done === 1'b1);
	end

	initial begin
		cycles = 0;
		while (cycles < MAX_CYCLES) begin
			@(posedge sclk);
			cycles++;
		end
		$display("Timeout after %0d cycles, the DUT stopped making progress", MAX_CYCLES);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
rtl/cam_cfg_pkg.sv
rtl/cfg_rom.sv
rtl/i2c_write_master.sv
rtl/cfg_sequencer.sv
rtl/cam_cfg_top.sv
tests/i2c_props.sv
tests/i2c_slave_model.sv
tests/tb_cam_cfg.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_cam_cfg
FILELIST  := all.f
OBJ_DIR   := obj_dir
RUN_FLAGS := +verilator+error+limit+1000
LOG       := sim.log

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	$(SIM) $(RUN_FLAGS) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
